// File: predecode_pkg.sv
package predecode_pkg;

        // Instruction and PC width.
        localparam int INSN_W = 32;

        // Block transfer register list width.
        localparam int REGLIST_W = 16;

        // IRQ mask bit in the mode word.
        localparam int CPSR_I = 7;

        // Condition field encodings.
        typedef enum logic [3:0] {
                EQ, NE, CS, CC, MI, PL, VS, VC,
                HI, LS, GE, LT, GT, LE, AL, NV
        } cond_t;

        // Instruction class from bits 27:25.
        typedef enum logic [2:0] {
                CLS_OTHER  = 3'b000,
                CLS_BLOCK  = 3'b100,
                CLS_BRANCH = 3'b101
        } iclass_t;

        // Static branch state.
        typedef enum logic [1:0] {
                SNT = 2'd0,
                WNT = 2'd1,
                WT  = 2'd2,
                ST  = 2'd3
        } taken_t;

        // Block transfer FSM states.
        typedef enum logic {
                MS_IDLE,
                MS_EXPAND
        } mem_state_t;

        // Anything that is not a block transfer or a branch is CLS_OTHER.
        function automatic iclass_t insn_class(input logic [INSN_W-1:0] insn);
                iclass_t cls;
                case (insn[27:25])
                CLS_BLOCK:  cls = CLS_BLOCK;
                CLS_BRANCH: cls = CLS_BRANCH;
                default:    cls = CLS_OTHER;
                endcase
                return cls;
        endfunction

endpackage

// File: predecode_reglist_scan.sv
`timescale 1ns/1ps

module predecode_reglist_scan (
        input  logic                                    i_clk,
        input  logic                                    i_reset,
        input  logic                                    i_load,
        input  logic                                    i_advance,
        input  logic                                    i_stall,
        input  logic [predecode_pkg::REGLIST_W-1:0]     i_list,
        output logic [3:0]                              o_reg,
        output logic [predecode_pkg::REGLIST_W-1:0]     o_rest
);

logic [predecode_pkg::REGLIST_W-1:0]    rest_ff;
logic [predecode_pkg::REGLIST_W-1:0]    src;

// First micro-op scans the fresh list, later ones the remainder.
assign src = i_load ? i_list : rest_ff;

// Lowest set bit wins.
always_comb
begin
        o_reg = '0;
        for (int i = predecode_pkg::REGLIST_W - 1; i >= 0; i--)
        begin
                if (src[i])
                        o_reg = 4'(i);
        end
end

// Drop the lowest set bit.
assign o_rest = src & (src - 1'b1);

always_ff @(posedge i_clk)
begin
        if (i_reset)
                rest_ff <= '0;
        else if (!i_stall && (i_load || i_advance))
                rest_ff <= o_rest;
end

endmodule

// File: predecode_uop_counter.sv
`timescale 1ns/1ps

module predecode_uop_counter (
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_clear,
        input  logic            i_step,
        input  logic            i_stall,
        output logic [3:0]      o_index
);

// Micro-op number within one block transfer.
// Sixteen registers at most, so the wrap never matters.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
                o_index <= '0;
        else if (i_stall)
                o_index <= o_index;
        else if (i_step)
                o_index <= o_index + 4'd1;
end

endmodule

// File: predecode_mem_fsm.sv
`timescale 1ns/1ps

module predecode_mem_fsm (
        input  logic                                    i_clk,
        input  logic                                    i_reset,
        input  logic                                    i_clear,
        input  logic                                    i_stall,
        input  logic [predecode_pkg::INSN_W-1:0]        i_insn,
        input  logic                                    i_insn_valid,
        input  logic [3:0]                              i_scan_reg,
        input  logic [predecode_pkg::REGLIST_W-1:0]     i_scan_rest,
        input  logic [3:0]                              i_uop_index,
        output logic [predecode_pkg::INSN_W-1:0]        o_uop_insn,
        output logic                                    o_uop_valid,
        output logic                                    o_stall_from_decode,
        output logic                                    o_scan_load,
        output logic                                    o_scan_advance,
        output logic                                    o_cnt_clear,
        output logic                                    o_cnt_step
);

predecode_pkg::mem_state_t              state_ff;
predecode_pkg::mem_state_t              state_nxt;
logic                                   is_block;
logic                                   expanding;
logic                                   more;
logic [predecode_pkg::INSN_W-1:0]       uop;

// Non-empty LDM/STM only. An empty list passes through as is.
assign is_block = i_insn_valid &&
                  (predecode_pkg::insn_class(i_insn) == predecode_pkg::CLS_BLOCK) &&
                  (i_insn[predecode_pkg::REGLIST_W-1:0] != '0);

assign o_scan_load    = (state_ff == predecode_pkg::MS_IDLE) && is_block;
assign o_scan_advance = (state_ff == predecode_pkg::MS_EXPAND);
assign expanding      = o_scan_load || o_scan_advance;

// Registers left after the one being issued now.
assign more = expanding && (i_scan_rest != '0);

// Single transfer: pre-indexed, up, word, no writeback, offset 4*i.
assign uop = {i_insn[31:28], 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, i_insn[20],
              i_insn[19:16], i_scan_reg, 6'd0, i_uop_index, 2'b00};

assign o_uop_insn          = expanding ? uop : i_insn;
assign o_uop_valid         = o_scan_advance || i_insn_valid;
assign o_stall_from_decode = more;
assign o_cnt_step          = more;

// Index returns to zero once the last micro-op really leaves.
assign o_cnt_clear = i_clear || (expanding && !more && !i_stall);

always_comb
begin
        state_nxt = state_ff;
        case (state_ff)
        predecode_pkg::MS_IDLE:
        begin
                if (o_scan_load && more)
                        state_nxt = predecode_pkg::MS_EXPAND;
        end
        predecode_pkg::MS_EXPAND:
        begin
                if (!more)
                        state_nxt = predecode_pkg::MS_IDLE;
        end
        default:
                state_nxt = predecode_pkg::MS_IDLE;
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
                state_ff <= predecode_pkg::MS_IDLE;
        else if (!i_stall)
                state_ff <= state_nxt;
end

// Fetch is held in idle only for a block transfer being split.
a_idle_stall_is_block: assert property (@(posedge i_clk) disable iff (i_reset)
        (state_ff == predecode_pkg::MS_IDLE && o_stall_from_decode) |->
        (i_insn_valid && i_insn[27:25] == predecode_pkg::CLS_BLOCK));

// Offsets keep climbing while the expansion is in flight.
a_index_steps: assert property (@(posedge i_clk) disable iff (i_reset)
        (state_ff == predecode_pkg::MS_EXPAND && more && !i_stall && !i_clear) |=>
        (i_uop_index == $past(i_uop_index) + 4'd1));

endmodule

// File: predecode_out_reg.sv
`timescale 1ns/1ps

module predecode_out_reg (
        input  logic                                    i_clk,
        input  logic                                    i_reset,
        input  logic                                    i_clear,
        input  logic                                    i_stall,
        input  logic [predecode_pkg::INSN_W-1:0]        i_insn,
        input  logic                                    i_insn_valid,
        input  logic [predecode_pkg::INSN_W-1:0]        i_pc,
        input  logic [predecode_pkg::INSN_W-1:0]        i_pc_plus_8,
        input  logic                                    i_irq,
        input  logic [predecode_pkg::INSN_W-1:0]        i_cpu_mode,
        input  predecode_pkg::taken_t                   i_taken_nxt,
        output logic [predecode_pkg::INSN_W-1:0]        o_insn_ff,
        output logic                                    o_insn_valid_ff,
        output logic [predecode_pkg::INSN_W-1:0]        o_pc_ff,
        output logic [predecode_pkg::INSN_W-1:0]        o_pc_plus_8_ff,
        output logic                                    o_irq_ff,
        output predecode_pkg::taken_t                   o_taken_ff
);

// Clear beats stall, stall beats update.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                o_insn_ff       <= '0;
                o_insn_valid_ff <= 1'b0;
                o_pc_ff         <= '0;
                o_pc_plus_8_ff  <= 32'd8;
                o_irq_ff        <= 1'b0;
                o_taken_ff      <= predecode_pkg::SNT;
        end
        else if (!i_stall)
        begin
                o_insn_ff       <= i_insn;
                o_insn_valid_ff <= i_insn_valid;
                o_pc_ff         <= i_pc;
                o_pc_plus_8_ff  <= i_pc_plus_8;
                // IRQ rides on a valid instruction, and only when unmasked.
                o_irq_ff        <= i_irq && i_insn_valid &&
                                   !i_cpu_mode[predecode_pkg::CPSR_I];
                o_taken_ff      <= i_taken_nxt;
        end
end

// A flush leaves a bubble behind.
a_clear_bubble: assert property (@(posedge i_clk)
        i_clear |=> !o_insn_valid_ff);

endmodule

// File: predecode_branch.sv
`timescale 1ns/1ps

module predecode_branch (
        input  logic [predecode_pkg::INSN_W-1:0]        i_insn,
        input  logic                                    i_insn_valid,
        input  logic [predecode_pkg::INSN_W-1:0]        i_pc_plus_8,
        input  predecode_pkg::taken_t                   i_taken,
        output logic                                    o_clear_from_decode,
        output logic [predecode_pkg::INSN_W-1:0]        o_pc_from_decode,
        output predecode_pkg::taken_t                   o_taken_nxt
);

predecode_pkg::cond_t                   cond;
logic                                   is_branch;
logic                                   is_al;
logic                                   predict_taken;
logic                                   take;
logic [predecode_pkg::INSN_W-1:0]       offset;

assign cond      = predecode_pkg::cond_t'(i_insn[31:28]);
assign is_branch = i_insn_valid &&
                   (predecode_pkg::insn_class(i_insn) == predecode_pkg::CLS_BRANCH);
assign is_al     = (cond == predecode_pkg::AL);

// Upper half of the state means taken.
assign predict_taken = (i_taken == predecode_pkg::WT) || (i_taken == predecode_pkg::ST);
assign take          = is_branch && (predict_taken || is_al);

// Word offset, sign extended.
assign offset = {{6{i_insn[23]}}, i_insn[23:0], 2'b00};

assign o_clear_from_decode = take;
assign o_pc_from_decode    = take ? (i_pc_plus_8 + offset) : '0;

// Unconditional branches saturate to strongly taken.
assign o_taken_nxt = (take && is_al) ? predecode_pkg::ST : i_taken;

endmodule

// File: predecode_top.sv
`timescale 1ns/1ps

module predecode_top (
        input  logic                                    i_clk,
        input  logic                                    i_reset,
        input  logic                                    i_clear,
        input  logic                                    i_stall,
        input  logic [predecode_pkg::INSN_W-1:0]        i_insn,
        input  logic                                    i_insn_valid,
        input  logic [predecode_pkg::INSN_W-1:0]        i_pc,
        input  logic [predecode_pkg::INSN_W-1:0]        i_pc_plus_8,
        input  predecode_pkg::taken_t                   i_taken,
        input  logic                                    i_irq,
        input  logic [predecode_pkg::INSN_W-1:0]        i_cpu_mode,
        output logic [predecode_pkg::INSN_W-1:0]        o_insn_ff,
        output logic                                    o_insn_valid_ff,
        output logic [predecode_pkg::INSN_W-1:0]        o_pc_ff,
        output logic [predecode_pkg::INSN_W-1:0]        o_pc_plus_8_ff,
        output logic                                    o_irq_ff,
        output predecode_pkg::taken_t                   o_taken_ff,
        output logic                                    o_stall_from_decode,
        output logic                                    o_clear_from_decode,
        output logic [predecode_pkg::INSN_W-1:0]        o_pc_from_decode
);

logic [predecode_pkg::INSN_W-1:0]       uop_insn;
logic                                   uop_valid;
logic                                   scan_load;
logic                                   scan_advance;
logic [3:0]                             scan_reg;
logic [predecode_pkg::REGLIST_W-1:0]    scan_rest;
logic                                   cnt_clear;
logic                                   cnt_step;
logic [3:0]                             uop_index;
predecode_pkg::taken_t                  taken_ff;

// Splits LDM/STM into single transfers.
predecode_mem_fsm u_mem_fsm (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_clear             (i_clear),
        .i_stall             (i_stall),
        .i_insn              (i_insn),
        .i_insn_valid        (i_insn_valid),
        .i_scan_reg          (scan_reg),
        .i_scan_rest         (scan_rest),
        .i_uop_index         (uop_index),
        .o_uop_insn          (uop_insn),
        .o_uop_valid         (uop_valid),
        .o_stall_from_decode (o_stall_from_decode),
        .o_scan_load         (scan_load),
        .o_scan_advance      (scan_advance),
        .o_cnt_clear         (cnt_clear),
        .o_cnt_step          (cnt_step)
);

predecode_reglist_scan u_reglist_scan (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_load    (scan_load),
        .i_advance (scan_advance),
        .i_stall   (i_stall),
        .i_list    (i_insn[predecode_pkg::REGLIST_W-1:0]),
        .o_reg     (scan_reg),
        .o_rest    (scan_rest)
);

predecode_uop_counter u_uop_counter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_clear (cnt_clear),
        .i_step  (cnt_step),
        .i_stall (i_stall),
        .o_index (uop_index)
);

// Taken state is captured with its instruction.
predecode_out_reg u_out_reg (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clear         (i_clear),
        .i_stall         (i_stall),
        .i_insn          (uop_insn),
        .i_insn_valid    (uop_valid),
        .i_pc            (i_pc),
        .i_pc_plus_8     (i_pc_plus_8),
        .i_irq           (i_irq),
        .i_cpu_mode      (i_cpu_mode),
        .i_taken_nxt     (i_taken),
        .o_insn_ff       (o_insn_ff),
        .o_insn_valid_ff (o_insn_valid_ff),
        .o_pc_ff         (o_pc_ff),
        .o_pc_plus_8_ff  (o_pc_plus_8_ff),
        .o_irq_ff        (o_irq_ff),
        .o_taken_ff      (taken_ff)
);

// Predicts on the registered instruction, same cycle it is visible.
predecode_branch u_branch (
        .i_insn              (o_insn_ff),
        .i_insn_valid        (o_insn_valid_ff),
        .i_pc_plus_8         (o_pc_plus_8_ff),
        .i_taken             (taken_ff),
        .o_clear_from_decode (o_clear_from_decode),
        .o_pc_from_decode    (o_pc_from_decode),
        .o_taken_nxt         (o_taken_ff)
);

endmodule

// File: tb_predecode.sv
`timescale 1ns/1ps

module tb_predecode;

localparam int          HALF_PERIOD   = 20;
localparam int          RESET_TIMEOUT = 40;
localparam int          MAX_LINES     = 200;
localparam logic [31:0] SEED          = 32'hc25e_fb65;

logic                                   i_clk;
logic                                   i_reset;
logic                                   i_clear;
logic                                   i_stall;
logic [predecode_pkg::INSN_W-1:0]       i_insn;
logic                                   i_insn_valid;
logic [predecode_pkg::INSN_W-1:0]       i_pc;
logic [predecode_pkg::INSN_W-1:0]       i_pc_plus_8;
predecode_pkg::taken_t                  i_taken;
logic                                   i_irq;
logic [predecode_pkg::INSN_W-1:0]       i_cpu_mode;
logic [predecode_pkg::INSN_W-1:0]       o_insn_ff;
logic                                   o_insn_valid_ff;
logic [predecode_pkg::INSN_W-1:0]       o_pc_ff;
logic [predecode_pkg::INSN_W-1:0]       o_pc_plus_8_ff;
logic                                   o_irq_ff;
predecode_pkg::taken_t                  o_taken_ff;
logic                                   o_stall_from_decode;
logic                                   o_clear_from_decode;
logic [predecode_pkg::INSN_W-1:0]       o_pc_from_decode;

// One trace line, inputs then expected values.
logic [7:0]                             f_test;
logic [1:0]                             f_rnd;
logic                                   f_clr;
logic                                   f_stl;
logic [predecode_pkg::INSN_W-1:0]       f_insn;
logic                                   f_v;
logic [predecode_pkg::INSN_W-1:0]       f_pc;
logic [1:0]                             f_tk;
logic                                   f_irq;
logic [7:0]                             f_mode;
logic [predecode_pkg::INSN_W-1:0]       e_insn;
logic                                   e_v;
logic [predecode_pkg::INSN_W-1:0]       e_pc;
logic                                   e_irq;
logic [1:0]                             e_tk;
logic                                   e_st;
logic                                   e_rd;
logic [predecode_pkg::INSN_W-1:0]       e_tgt;

logic [8*160-1:0]                       line_buf;
logic [predecode_pkg::INSN_W-1:0]       prev_pc;
int                                     fd;
int                                     fields;
int                                     line_no;
int                                     waited;
int                                     cur_test;
int                                     test_errors;
int                                     tests_run;
int                                     tests_failed;
int                                     checks;
int                                     errors;
int unsigned                            seed_draw;
bit                                     abort;
bit                                     eof;

predecode_top i_dut (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_clear             (i_clear),
        .i_stall             (i_stall),
        .i_insn              (i_insn),
        .i_insn_valid        (i_insn_valid),
        .i_pc                (i_pc),
        .i_pc_plus_8         (i_pc_plus_8),
        .i_taken             (i_taken),
        .i_irq               (i_irq),
        .i_cpu_mode          (i_cpu_mode),
        .o_insn_ff           (o_insn_ff),
        .o_insn_valid_ff     (o_insn_valid_ff),
        .o_pc_ff             (o_pc_ff),
        .o_pc_plus_8_ff      (o_pc_plus_8_ff),
        .o_irq_ff            (o_irq_ff),
        .o_taken_ff          (o_taken_ff),
        .o_stall_from_decode (o_stall_from_decode),
        .o_clear_from_decode (o_clear_from_decode),
        .o_pc_from_decode    (o_pc_from_decode)
);

always #(HALF_PERIOD) i_clk = ~i_clk;

// Reset for ten clock cycles.
initial
begin
        i_reset = 1'b1;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
end

task automatic check_insn(input string name, input logic [predecode_pkg::INSN_W-1:0] got,
                          input logic [predecode_pkg::INSN_W-1:0] exp);
        checks++;
        if (got !== exp)
        begin
                errors++;
                test_errors++;
                $display("ERROR %s: got 0x%h, expected 0x%h (test %0d, line %0d)",
                         name, got, exp, cur_test, line_no);
        end
endtask

task automatic check_taken(input string name, input predecode_pkg::taken_t got,
                           input predecode_pkg::taken_t exp);
        checks++;
        if (got !== exp)
        begin
                errors++;
                test_errors++;
                $display("ERROR %s: got 0x%h, expected 0x%h (test %0d, line %0d)",
                         name, got, exp, cur_test, line_no);
        end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
                errors++;
                test_errors++;
                $display("ERROR %s: got 0x%h, expected 0x%h (test %0d, line %0d)",
                         name, got, exp, cur_test, line_no);
        end
endtask

// Everything is zero under reset except PC plus 8.
task automatic compare_reset_outputs();
        check_insn("o_insn_ff", o_insn_ff, '0);
        check_flag("o_insn_valid_ff", o_insn_valid_ff, 1'b0);
        check_insn("o_pc_ff", o_pc_ff, '0);
        check_insn("o_pc_plus_8_ff", o_pc_plus_8_ff, 32'd8);
        check_flag("o_irq_ff", o_irq_ff, 1'b0);
        check_taken("o_taken_ff", o_taken_ff, predecode_pkg::SNT);
        check_flag("o_stall_from_decode", o_stall_from_decode, 1'b0);
        check_flag("o_clear_from_decode", o_clear_from_decode, 1'b0);
endtask

task automatic report_test();
        tests_run++;
        if (test_errors == 0)
                $display("test %0d: ok", cur_test);
        else
        begin
                tests_failed++;
                $display("test %0d: %0d mismatches", cur_test, test_errors);
        end
        test_errors = 0;
endtask

// Drive one cycle on the falling edge, then look at the settled outputs.
task automatic play_line();
        logic [predecode_pkg::INSN_W-1:0] pc;
        logic [predecode_pkg::INSN_W-1:0] exp_pc;

        @(negedge i_clk);
        pc = f_rnd[0] ? ($urandom & 32'hffff_fffc) : f_pc;
        i_clear      = f_clr;
        i_stall      = f_stl;
        i_insn       = f_insn;
        i_insn_valid = f_v;
        i_pc         = pc;
        i_pc_plus_8  = pc + 32'd8;
        i_taken      = predecode_pkg::taken_t'(f_tk);
        i_irq        = f_irq;
        i_cpu_mode   = {24'd0, f_mode};
        #1;
        // Random PCs show up one cycle after they were driven.
        exp_pc = f_rnd[1] ? prev_pc : e_pc;
        check_insn("o_insn_ff", o_insn_ff, e_insn);
        check_flag("o_insn_valid_ff", o_insn_valid_ff, e_v);
        check_insn("o_pc_ff", o_pc_ff, exp_pc);
        check_insn("o_pc_plus_8_ff", o_pc_plus_8_ff, exp_pc + 32'd8);
        check_flag("o_irq_ff", o_irq_ff, e_irq);
        check_taken("o_taken_ff", o_taken_ff, predecode_pkg::taken_t'(e_tk));
        check_flag("o_stall_from_decode", o_stall_from_decode, e_st);
        check_flag("o_clear_from_decode", o_clear_from_decode, e_rd);
        if (e_rd)
                check_insn("o_pc_from_decode", o_pc_from_decode, e_tgt);
        prev_pc = pc;
endtask

initial
begin
        i_clk        = 1'b0;
        i_clear      = 1'b0;
        i_stall      = 1'b0;
        i_insn       = '0;
        i_insn_valid = 1'b0;
        i_pc         = '0;
        i_pc_plus_8  = 32'd8;
        i_taken      = predecode_pkg::SNT;
        i_irq        = 1'b0;
        i_cpu_mode   = '0;
        seed_draw    = $urandom(SEED);
        prev_pc      = '0;
        abort        = 1'b0;
        eof          = 1'b0;
        cur_test     = 0;
        line_no      = 0;

        waited = 0;
        while (i_reset && waited < RESET_TIMEOUT)
        begin
                @(negedge i_clk);
                #1;
                waited++;
                if (i_reset)
                        compare_reset_outputs();
        end
        if (i_reset)
        begin
                $display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
                abort = 1'b1;
        end

        if (!abort)
        begin
                fd = $fopen("predecode_trace.txt", "r");
                if (fd == 0)
                begin
                        $display("could not open predecode_trace.txt for reading");
                        abort = 1'b1;
                end
        end

        while (!abort && !eof && line_no < MAX_LINES)
        begin
                if ($fgets(line_buf, fd) == 0)
                        eof = 1'b1;
                else
                begin
                        line_no++;
                        fields = $sscanf(line_buf,
                                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f_test, f_rnd, f_clr, f_stl, f_insn, f_v, f_pc, f_tk,
                                f_irq, f_mode, e_insn, e_v, e_pc, e_irq, e_tk, e_st,
                                e_rd, e_tgt);
                        if (fields == 18)
                        begin
                                if (cur_test != 0 && f_test != cur_test)
                                        report_test();
                                cur_test = f_test;
                                play_line();
                        end
                        else if (fields > 0)
                        begin
                                $display("trace line %0d has %0d fields instead of 18",
                                         line_no, fields);
                                abort = 1'b1;
                        end
                end
        end
        if (!abort && !eof)
        begin
                $display("trace did not end within %0d lines", MAX_LINES);
                abort = 1'b1;
        end
        if (cur_test != 0)
                report_test();

        $display("%0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (!abort && errors == 0 && tests_run > 0)
                $display("test passed");
        else
                $display("test failed");
        $finish;
end

endmodule

// File: predecode_trace.txt
# test rnd(b0 drive random pc, b1 expect previous pc) clear stall insn valid pc taken irq mode
# then expected: insn valid pc irq taken stall redirect target, all hex
01 0 0 0 00000000 0 00000000 0 0 13  00000000 0 00000000 0 0 0 0 00000000
01 0 0 0 E0821003 1 00001000 0 0 13  00000000 0 00000000 0 0 0 0 00000000
01 1 0 0 E1A00000 1 00000000 0 0 13  E0821003 1 00001000 0 0 0 0 00000000
01 2 0 0 00000000 0 00000000 0 0 13  E1A00000 1 00000000 0 0 0 0 00000000
01 0 0 0 00000000 0 00000000 0 0 13  00000000 0 00000000 0 0 0 0 00000000
02 0 0 0 E8950212 1 00002000 0 0 13  00000000 0 00000000 0 0 1 0 00000000
02 0 0 0 E8950212 1 00002000 0 0 13  E5951000 1 00002000 0 0 1 0 00000000
02 0 0 0 E8950212 1 00002000 0 0 13  E5954004 1 00002000 0 0 0 0 00000000
02 0 0 0 00000000 0 00000000 0 0 13  E5959008 1 00002000 0 0 0 0 00000000
02 0 0 0 E8950000 1 00002100 0 0 13  00000000 0 00000000 0 0 0 0 00000000
02 0 0 0 00000000 0 00000000 0 0 13  E8950000 1 00002100 0 0 0 0 00000000
03 0 0 0 1A000010 1 00003000 2 0 13  00000000 0 00000000 0 0 0 0 00000000
03 0 0 0 00000000 0 00000000 0 0 13  1A000010 1 00003000 0 2 0 1 00003048
03 0 0 0 1A000010 1 00003100 1 0 13  00000000 0 00000000 0 0 0 0 00000000
03 0 0 0 00000000 0 00000000 0 0 13  1A000010 1 00003100 0 1 0 0 00000000
03 0 0 0 EAFFFFFE 1 00003200 0 0 13  00000000 0 00000000 0 0 0 0 00000000
03 0 0 0 00000000 0 00000000 0 0 13  EAFFFFFE 1 00003200 0 3 0 1 00003200
04 0 0 0 E8950212 1 00004000 0 0 13  00000000 0 00000000 0 0 1 0 00000000
04 0 1 0 E8950212 1 00004000 0 0 13  E5951000 1 00004000 0 0 1 0 00000000
04 0 0 0 00000000 0 00000000 0 0 13  00000000 0 00000000 0 0 0 0 00000000
04 0 0 0 E0821003 1 00004100 1 0 13  00000000 0 00000000 0 0 0 0 00000000
04 0 0 1 E1A00000 1 00004200 0 0 13  E0821003 1 00004100 0 1 0 0 00000000
04 0 0 1 E1A00000 1 00004200 0 0 13  E0821003 1 00004100 0 1 0 0 00000000
04 0 0 0 E1A00000 1 00004200 0 0 13  E0821003 1 00004100 0 1 0 0 00000000
04 0 0 0 00000000 0 00000000 0 0 13  E1A00000 1 00004200 0 0 0 0 00000000
05 0 0 0 E1A00000 1 00005000 0 1 13  00000000 0 00000000 0 0 0 0 00000000
05 0 0 0 E1A00000 1 00005004 0 1 93  E1A00000 1 00005000 1 0 0 0 00000000
05 0 0 0 00000000 0 00000000 0 1 13  E1A00000 1 00005004 0 0 0 0 00000000
05 0 0 0 00000000 0 00000000 0 0 13  00000000 0 00000000 0 0 0 0 00000000

// File: vlog.f
predecode_pkg.sv
predecode_reglist_scan.sv
predecode_uop_counter.sv
predecode_mem_fsm.sv
predecode_out_reg.sv
predecode_branch.sv
predecode_top.sv
tb_predecode.sv

// File: Bender.yml
package:
  name: predecode

sources:
  - predecode_pkg.sv
  - predecode_reglist_scan.sv
  - predecode_uop_counter.sv
  - predecode_mem_fsm.sv
  - predecode_out_reg.sv
  - predecode_branch.sv
  - predecode_top.sv
  - target: test
    files:
      - tb_predecode.sv
